//--- verilog/gpcTile_cfg.svh
// region bit positions, region codes, memory depths and control register count
`ifndef GPC_TILE_CFG_SVH
`define GPC_TILE_CFG_SVH

//========================================
// fabric address region select
//========================================
`define REGION_MSB 23 // top region bit
`define REGION_LSB 22

// region codes, code 3 is unmapped
`define I_MEM_REGION 2'd0 // instruction memory
`define D_MEM_REGION 2'd1 // data memory
`define CR_REGION    2'd2 // control registers in dataMem

//========================================
// local memories
//========================================
`define I_MEM_WORDS 256 // 32b words
`define D_MEM_WORDS 256

// word index width, both memories
`define MEM_ADDR_W 8

//========================================
// control register bank
//========================================
`define CR_COUNT 4 // reg 0 is core id, rest scratch

`endif

//--- verilog/gpcTilePkg.sv
// fabric opcode enum, fabric address union, fabric request/response and memory request structs
`include "gpcTile_cfg.svh"

package gpcTilePkg;

    //========================================
    // fabric opcodes
    //========================================
    typedef enum logic [1:0] {
        RD     = 2'b00, // read request
        WR     = 2'b01, // write, no response
        RD_RSP = 2'b10  // read response
    } tOpcode;

    // fabric address, raw word or decoded fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31-`REGION_MSB-1:0]          unused;  // above region
            logic [`REGION_MSB-`REGION_LSB:0]   region;  // I / D / CR / unmapped
            logic [`REGION_LSB-3:0]             wordIdx; // 32b word inside region
            logic [1:0]                         byteOff; // ignored, word access only
        } fld;
    } tFabAddr;

    //========================================
    // fabric request / response
    //========================================
    typedef struct packed {
        logic        valid;
        tOpcode      opcode;
        tFabAddr     addr;
        logic [31:0] data; // write data
    } tFabReq;

    typedef struct packed {
        logic        valid;
        tOpcode      opcode; // always RD_RSP
        logic [31:0] addr;   // echo of request address
        logic [31:0] data;
    } tFabRsp;

    // fabric port to one memory
    typedef struct packed {
        logic                   rdEn;
        logic                   wrEn;
        logic [`MEM_ADDR_W-1:0] wordIdx;
        logic [31:0]            wrData;
    } tMemReq;

endpackage

//--- verilog/instrMem.sv
// instruction memory with core fetch port and fabric read/write port
`include "gpcTile_cfg.svh"

module instrMem (
    input  logic                   QClk,
    // core fetch
    input  logic [`MEM_ADDR_W-1:0] fetchPc,    // word index
    output logic [31:0]            fetchInstr, // valid one cycle after fetchPc
    // fabric side
    input  gpcTilePkg::tMemReq     fabMemReq,
    output logic [31:0]            fabRdData   // valid one cycle after rdEn
);

    logic [31:0] mem [`I_MEM_WORDS]; // no reset on contents

    //========================================
    // fetch port, read only
    //========================================
    always_ff @(posedge QClk) begin
        fetchInstr <= mem[fetchPc]; // always enabled
    end

    //========================================
    // fabric port
    //========================================
    always_ff @(posedge QClk) begin
        if (fabMemReq.rdEn) begin
            fabRdData <= mem[fabMemReq.wordIdx]; // old data on same-cycle write
        end
        if (fabMemReq.wrEn) begin
            mem[fabMemReq.wordIdx] <= fabMemReq.wrData; // full word only
        end
    end

    // fabricPort decodes one opcode per request, never both strobes
    fabRdWrExcl: assert property (
        @(posedge QClk) !((fabMemReq.rdEn === 1'b1) && (fabMemReq.wrEn === 1'b1))
    ) else $error("instrMem: fabric rdEn and wrEn together");

endmodule

//--- verilog/dataMem.sv
// data memory with byte-enabled core port, fabric port and control register bank
`include "gpcTile_cfg.svh"

module dataMem (
    input  logic                   QClk,
    input  logic                   rstN,
    input  logic [7:0]             coreId,
    // core load/store
    input  logic                   coreRdEn,
    input  logic                   coreWrEn,
    input  logic [`MEM_ADDR_W-1:0] coreAddr,   // word index
    input  logic [3:0]             coreByteEn,
    input  logic [31:0]            coreWrData,
    output logic [31:0]            coreRdData, // one cycle after coreRdEn
    // fabric side
    input  gpcTilePkg::tMemReq     fabMemReq,
    input  logic                   crSel,      // fabric targets control regs
    output logic [31:0]            fabRdData
);

    localparam int crIdxW = $clog2(`CR_COUNT);

    logic [31:0]       mem [`D_MEM_WORDS];       // contents not reset
    logic [31:0]       crReg [1:`CR_COUNT-1];    // scratch regs, reg 0 has no storage
    logic [crIdxW-1:0] crIdx;
    logic [31:0]       crRdVal;
    logic              arrWr;
    logic              crWr;

    //========================================
    // fabric decode
    //========================================
    assign crIdx = fabMemReq.wordIdx[crIdxW-1:0]; // low bits pick the reg
    assign arrWr = fabMemReq.wrEn && !crSel;
    assign crWr  = fabMemReq.wrEn && crSel && (crIdx != '0); // reg 0 read only

    // control register read value
    always_comb begin
        if (crIdx == '0) begin
            crRdVal = 32'(coreId); // zero extended
        end else begin
            crRdVal = crReg[crIdx];
        end
    end

    //========================================
    // array, core and fabric ports
    //========================================
    always_ff @(posedge QClk) begin
        if (coreRdEn) begin
            coreRdData <= mem[coreAddr]; // old value on collision
        end
        if (coreWrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (coreByteEn[b]) begin
                    mem[coreAddr][b*8 +: 8] <= coreWrData[b*8 +: 8];
                end
            end
        end
        // last assignment, so fabric wins a same-word collision
        if (arrWr) begin
            mem[fabMemReq.wordIdx] <= fabMemReq.wrData;
        end
        if (fabMemReq.rdEn) begin
            fabRdData <= crSel ? crRdVal : mem[fabMemReq.wordIdx];
        end
    end

    //========================================
    // control registers
    //========================================
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            for (int i = 1; i < `CR_COUNT; i++) begin
                crReg[i] <= '0;
            end
        end else if (crWr) begin
            crReg[crIdx] <= fabMemReq.wrData;
        end
    end

    // core issues one access per cycle
    coreRdWrExcl: assert property (
        @(posedge QClk) disable iff (!rstN) !(coreRdEn && coreWrEn)
    ) else $error("dataMem: core load and store in same cycle");

endmodule

//--- verilog/fabricPort.sv
// fabric request sampling, region decode, memory request steering and read response register
`include "gpcTile_cfg.svh"

module fabricPort (
    input  logic               QClk,
    input  logic               rstN,
    input  gpcTilePkg::tFabReq fabReq,
    output gpcTilePkg::tFabRsp fabRsp,
    output gpcTilePkg::tMemReq iMemReq,
    output gpcTilePkg::tMemReq dMemReq,
    output logic               crSel,
    input  logic [31:0]        iMemRdData, // Q504
    input  logic [31:0]        dMemRdData  // Q504
);

    import gpcTilePkg::*;

    tFabReq                           reqQ503;
    logic                             rdEnQ503;
    logic                             wrEnQ503;
    logic                             iHitQ503;
    logic                             dHitQ503;
    logic                             crHitQ503;
    logic [`REGION_MSB-`REGION_LSB:0] regionQ504;
    logic [31:0]                      addrQ504;
    logic                             rspValidQ504;
    logic [31:0]                      rspDataQ504;

    //========================================
    // Q503 sample request
    //========================================
    always_ff @(posedge QClk) begin
        reqQ503 <= fabReq;
        if (!rstN) begin
            reqQ503.valid <= 1'b0; // payload kept as is
        end
    end

    assign rdEnQ503  = reqQ503.valid && (reqQ503.opcode == RD);
    assign wrEnQ503  = reqQ503.valid && (reqQ503.opcode == WR);
    assign iHitQ503  = (reqQ503.addr.fld.region == `I_MEM_REGION);
    assign dHitQ503  = (reqQ503.addr.fld.region == `D_MEM_REGION);
    assign crHitQ503 = (reqQ503.addr.fld.region == `CR_REGION);

    // steer to matching memory only, unmapped hits neither
    always_comb begin
        iMemReq.rdEn    = rdEnQ503 && iHitQ503;
        iMemReq.wrEn    = wrEnQ503 && iHitQ503;
        iMemReq.wordIdx = reqQ503.addr.fld.wordIdx[`MEM_ADDR_W-1:0];
        iMemReq.wrData  = reqQ503.data;
        dMemReq.rdEn    = rdEnQ503 && (dHitQ503 || crHitQ503); // CR lives in dataMem
        dMemReq.wrEn    = wrEnQ503 && (dHitQ503 || crHitQ503);
        dMemReq.wordIdx = reqQ503.addr.fld.wordIdx[`MEM_ADDR_W-1:0];
        dMemReq.wrData  = reqQ503.data;
    end

    assign crSel = crHitQ503; // level, qualified by dMemReq enables

    //========================================
    // Q504 memory read data
    //========================================
    always_ff @(posedge QClk) begin
        if (!rstN) begin
            rspValidQ504 <= 1'b0;
        end else begin
            rspValidQ504 <= rdEnQ503; // writes give no response
        end
    end

    always_ff @(posedge QClk) begin
        regionQ504 <= reqQ503.addr.fld.region; // selects read data
        addrQ504   <= reqQ503.addr.raw;        // echoed in response
    end

    always_comb begin
        case (regionQ504)
            `I_MEM_REGION: rspDataQ504 = iMemRdData;
            `D_MEM_REGION,
            `CR_REGION:    rspDataQ504 = dMemRdData;
            default:       rspDataQ504 = '0; // unmapped reads zero
        endcase
    end

    //========================================
    // response register
    //========================================
    always_ff @(posedge QClk) begin
        fabRsp.valid  <= rspValidQ504;
        fabRsp.opcode <= RD_RSP;
        fabRsp.addr   <= addrQ504;
        fabRsp.data   <= rspDataQ504;
        if (!rstN) begin
            fabRsp.valid <= 1'b0;
        end
    end

    // every response traces back to a sampled RD two stages earlier
    rspFromRd: assert property (
        @(posedge QClk) disable iff (!rstN) fabRsp.valid |-> $past(rdEnQ503, 2)
    ) else $error("fabricPort: response without sampled RD");

endmodule

//--- verilog/gpcTile.sv
// tile top, fabric port plus instruction and data memories
`include "gpcTile_cfg.svh"

module gpcTile (
    input  logic                   QClk,
    input  logic                   rstN,
    input  logic [7:0]             coreId,
    // ring fabric
    input  gpcTilePkg::tFabReq     fabReq,
    output gpcTilePkg::tFabRsp     fabRsp,
    // core fetch
    input  logic [`MEM_ADDR_W-1:0] fetchPc,
    output logic [31:0]            fetchInstr,
    // core load/store
    input  logic                   coreRdEn,
    input  logic                   coreWrEn,
    input  logic [`MEM_ADDR_W-1:0] coreAddr,
    input  logic [3:0]             coreByteEn,
    input  logic [31:0]            coreWrData,
    output logic [31:0]            coreRdData
);

    import gpcTilePkg::*;

    tMemReq      iMemReq;    // Q503
    tMemReq      dMemReq;    // Q503
    logic        crSel;
    logic [31:0] iMemRdData; // Q504
    logic [31:0] dMemRdData; // Q504

    //========================================
    // fabric port
    //========================================
    fabricPort fabricPort (
        .QClk       (QClk),
        .rstN       (rstN),
        .fabReq     (fabReq),
        .fabRsp     (fabRsp),
        .iMemReq    (iMemReq),
        .dMemReq    (dMemReq),
        .crSel      (crSel),
        .iMemRdData (iMemRdData),
        .dMemRdData (dMemRdData)
    );

    //========================================
    // memories
    //========================================
    instrMem instrMem (
        .QClk       (QClk),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr),
        .fabMemReq  (iMemReq),
        .fabRdData  (iMemRdData)
    );

    dataMem dataMem (
        .QClk       (QClk),
        .rstN       (rstN),
        .coreId     (coreId),     // read back as CR 0
        .coreRdEn   (coreRdEn),
        .coreWrEn   (coreWrEn),
        .coreAddr   (coreAddr),
        .coreByteEn (coreByteEn),
        .coreWrData (coreWrData),
        .coreRdData (coreRdData),
        .fabMemReq  (dMemReq),
        .crSel      (crSel),
        .fabRdData  (dMemRdData)
    );

endmodule

//--- tb/gpcTileTb.sv
// tile testbench with clock, reset, fabric and core stimulus, reference model and checker
`include "gpcTile_cfg.svh"

module gpcTileTb;

    import gpcTilePkg::*;

    // one core-side access per cycle
    typedef struct packed {
        logic        rdEn;
        logic        wrEn;
        logic [7:0]  addr;
        logic [3:0]  be;
        logic [31:0] wd;
        logic [7:0]  pc;
    } tCoreOp;

    // expected value tagged with the cycle it shows up
    typedef struct packed {
        logic [31:0] due;
        logic [31:0] addr;
        logic [31:0] data;
    } tExp;

    localparam tFabReq noFab = '0;

    logic        QClk;
    logic        rstN;
    logic [7:0]  coreId;
    tFabReq      fabReq;
    tFabRsp      fabRsp;
    logic [7:0]  fetchPc;
    logic [31:0] fetchInstr;
    logic        coreRdEn;
    logic        coreWrEn;
    logic [7:0]  coreAddr;
    logic [3:0]  coreByteEn;
    logic [31:0] coreWrData;
    logic [31:0] coreRdData;

    // shadow state of the tile
    logic [31:0] iShadow [`I_MEM_WORDS];
    logic [31:0] dShadow [`D_MEM_WORDS];
    logic [31:0] crShadow [`CR_COUNT];
    tFabReq      pendWr;        // fabric write lands one step after issue
    tExp         rspQ [$];      // fabric read responses
    tExp         fetchQ [$];
    tExp         coreQ [$];
    int          cyc;           // counts rising edges
    bit          coreChk;       // fetch and load checks on
    int          nChecks;
    int          nErrors;
    int          flowErrors;    // timeouts and leftovers

    gpcTile dut_i (
        .QClk       (QClk),
        .rstN       (rstN),
        .coreId     (coreId),
        .fabReq     (fabReq),
        .fabRsp     (fabRsp),
        .fetchPc    (fetchPc),
        .fetchInstr (fetchInstr),
        .coreRdEn   (coreRdEn),
        .coreWrEn   (coreWrEn),
        .coreAddr   (coreAddr),
        .coreByteEn (coreByteEn),
        .coreWrData (coreWrData),
        .coreRdData (coreRdData)
    );

    //========================================
    // clock and reset
    //========================================
    initial begin
        QClk = 1'b0;
        cyc  = 0;
        forever begin
            #50 QClk = 1'b1;
            cyc = cyc + 1;
            #50 QClk = 1'b0;
        end
    end

    initial begin
        rstN = 1'b0;
        repeat (16) @(posedge QClk);
        #10 rstN = 1'b1;
    end

    //========================================
    // request builders and reference model
    //========================================
    function automatic tFabReq fabOp(input tOpcode op, input logic [1:0] region,
                                     input logic [7:0] idx, input logic [31:0] data);
        tFabReq r;
        r = '0;
        r.valid            = 1'b1;
        r.opcode           = op;
        r.addr.fld.region  = region;
        r.addr.fld.wordIdx = 20'(idx);
        r.data             = data;
        return r;
    endfunction

    function automatic tCoreOp coreOp(input logic rdEn, input logic wrEn, input logic [7:0] addr,
                                      input logic [3:0] be, input logic [31:0] wd,
                                      input logic [7:0] pc);
        return {rdEn, wrEn, addr, be, wd, pc};
    endfunction

    function automatic tCoreOp coreIdle(input logic [7:0] pc);
        return coreOp(1'b0, 1'b0, 8'h00, 4'h0, 32'h0, pc);
    endfunction

    // preload word unique to each region and index
    function automatic logic [31:0] fillWord(input logic [1:0] region, input logic [7:0] idx);
        return {6'h2B, region, idx, ~idx, idx ^ 8'hA5};
    endfunction

    // expected fabric read data from the shadow state
    function automatic logic [31:0] expectedRead(input tFabAddr a);
        logic [7:0] idx;
        idx = a.fld.wordIdx[7:0];
        case (a.fld.region)
            `I_MEM_REGION: return iShadow[idx];
            `D_MEM_REGION: return dShadow[idx];
            `CR_REGION:    return (idx[1:0] == 2'd0) ? {24'h0, coreId} : crShadow[idx[1:0]];
            default:       return 32'h0; // unmapped
        endcase
    endfunction

    function automatic void applyFabWrite(input tFabReq r);
        logic [7:0] idx;
        idx = r.addr.fld.wordIdx[7:0];
        case (r.addr.fld.region)
            `I_MEM_REGION: iShadow[idx] = r.data;
            `D_MEM_REGION: dShadow[idx] = r.data;
            `CR_REGION: begin
                if (idx[1:0] != 2'd0) crShadow[idx[1:0]] = r.data; // reg 0 read only
            end
            default: ; // unmapped writes dropped
        endcase
    endfunction

    // one cycle of stimulus with the model updated in edge order
    task automatic stepCycle(input tFabReq req, input tCoreOp c);
        tExp e;
        @(posedge QClk);
        #10;
        e     = '0;
        e.due = 32'(cyc + 1);
        // fetch and load see the array before this edge's writes
        if (coreChk) begin
            e.addr = 32'(c.pc);
            e.data = iShadow[c.pc];
            fetchQ.push_back(e);
        end
        if (coreChk && c.rdEn) begin
            e.addr = 32'(c.addr);
            e.data = dShadow[c.addr];
            coreQ.push_back(e);
        end
        if (c.wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (c.be[b]) dShadow[c.addr][b*8 +: 8] = c.wd[b*8 +: 8]; // byte merge
            end
        end
        // last step's fabric write lands on the same edge and goes last so it wins
        if (pendWr.valid) applyFabWrite(pendWr);
        pendWr = '0;
        if (req.valid && req.opcode == RD) begin
            e.due  = 32'(cyc + 3);
            e.addr = req.addr.raw;
            e.data = expectedRead(req.addr);
            rspQ.push_back(e);
        end else if (req.valid && req.opcode == WR) begin
            pendWr = req;
        end
        fabReq     = req;
        fetchPc    = c.pc;
        coreRdEn   = c.rdEn;
        coreWrEn   = c.wrEn;
        coreAddr   = c.addr;
        coreByteEn = c.be;
        coreWrData = c.wd;
    endtask

    //========================================
    // comparing process
    //========================================
    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        nChecks++;
        if (got !== want) begin
            nErrors++;
            $display("CHECK FAILED time %0t %s expected %h got %h", $time, name, want, got);
        end
    endtask

    always @(negedge QClk) begin
        tExp e;
        if (rstN === 1'b1) begin
            if (fabRsp.valid === 1'b1) begin
                if (rspQ.size() == 0 || rspQ[0].due != 32'(cyc)) begin
                    nErrors++;
                    $display("unexpected fabric response at time %0t, address %h",
                             $time, fabRsp.addr);
                end else begin
                    e = rspQ.pop_front();
                    checkVal("fabRsp.opcode", 32'(fabRsp.opcode), 32'(RD_RSP));
                    checkVal("fabRsp.addr", fabRsp.addr, e.addr);
                    checkVal("fabRsp.data", fabRsp.data, e.data);
                end
            end
            if (rspQ.size() != 0 && rspQ[0].due < 32'(cyc)) begin
                e = rspQ.pop_front();
                nErrors++;
                $display("no fabric response at time %0t for read of %h", $time, e.addr);
            end
            if (fetchQ.size() != 0 && fetchQ[0].due == 32'(cyc)) begin
                e = fetchQ.pop_front();
                checkVal("fetchInstr", fetchInstr, e.data);
            end
            if (coreQ.size() != 0 && coreQ[0].due == 32'(cyc)) begin
                e = coreQ.pop_front();
                checkVal("coreRdData", coreRdData, e.data);
            end
        end
    end

    //========================================
    // stimulus
    //========================================
    initial begin
        int     guard;
        int     op;
        tOpcode fabOpc;
        tFabReq r;
        tCoreOp c;
        coreId     = 8'h3C;
        fabReq     = '0;
        fetchPc    = 8'h00;
        coreRdEn   = 1'b0;
        coreWrEn   = 1'b0;
        coreAddr   = 8'h00;
        coreByteEn = 4'h0;
        coreWrData = 32'h0;
        pendWr     = '0;
        coreChk    = 1'b0;
        nChecks    = 0;
        nErrors    = 0;
        flowErrors = 0;
        for (int i = 0; i < `CR_COUNT; i++) crShadow[i] = 32'h0; // cleared by reset
        void'($urandom(54));
        guard = 0;
        while (rstN !== 1'b1 && guard < 40) begin
            @(posedge QClk);
            guard++;
        end
        if (rstN !== 1'b1) begin
            flowErrors++;
            $display("reset release not seen within %0d cycles", guard);
        end else begin
            // preload both arrays
            for (int i = 0; i < `I_MEM_WORDS; i++) begin
                stepCycle(fabOp(WR, `I_MEM_REGION, 8'(i), fillWord(`I_MEM_REGION, 8'(i))),
                          coreIdle(8'h00));
            end
            for (int i = 0; i < `D_MEM_WORDS; i++) begin
                stepCycle(fabOp(WR, `D_MEM_REGION, 8'(i), fillWord(`D_MEM_REGION, 8'(i))),
                          coreIdle(8'h00));
            end
            coreChk = 1'b1;
            // control regs right after reset
            for (int i = 0; i < `CR_COUNT; i++) stepCycle(fabOp(RD, `CR_REGION, 8'(i), 0),
                                                          coreIdle(8'h00));
            // I region write followed by read back and fetch
            stepCycle(fabOp(WR, `I_MEM_REGION, 8'h21, 32'hCAFE_0001), coreIdle(8'h00));
            stepCycle(fabOp(RD, `I_MEM_REGION, 8'h21, 0), coreIdle(8'h21));
            stepCycle(noFab, coreIdle(8'h21));
            // byte stores merge and are seen by core load and fabric read
            stepCycle(noFab, coreOp(1'b0, 1'b1, 8'h09, 4'b0101, 32'h1122_3344, 8'h00));
            stepCycle(noFab, coreOp(1'b0, 1'b1, 8'h09, 4'b1000, 32'hAABB_CCDD, 8'h00));
            stepCycle(noFab, coreOp(1'b1, 1'b0, 8'h09, 4'h0, 32'h0, 8'h00));
            stepCycle(fabOp(RD, `D_MEM_REGION, 8'h09, 0), coreIdle(8'h00));
            // control reg writes where reg 0 ignores its write
            for (int i = 0; i < `CR_COUNT; i++) stepCycle(fabOp(WR, `CR_REGION, 8'(i),
                                                          32'h5C00_0000 + i), coreIdle(8'h00));
            for (int i = 0; i < `CR_COUNT; i++) stepCycle(fabOp(RD, `CR_REGION, 8'(i), 0),
                                                          coreIdle(8'h00));
            // unmapped region drops the write and reads zero
            stepCycle(fabOp(WR, 2'd3, 8'h07, 32'hDEAD_BEEF), coreIdle(8'h07));
            stepCycle(fabOp(RD, 2'd3, 8'h07, 0), coreIdle(8'h00));
            stepCycle(fabOp(RD, `I_MEM_REGION, 8'h07, 0), coreIdle(8'h00));
            stepCycle(fabOp(RD, `D_MEM_REGION, 8'h07, 0), coreIdle(8'h00));
            // fabric write and core store to one word on the same edge
            stepCycle(fabOp(WR, `D_MEM_REGION, 8'h03, 32'h0F0F_0F0F), coreIdle(8'h00));
            stepCycle(noFab, coreOp(1'b0, 1'b1, 8'h03, 4'hF, 32'h7777_7777, 8'h00));
            stepCycle(fabOp(RD, `D_MEM_REGION, 8'h03, 0),
                      coreOp(1'b1, 1'b0, 8'h03, 4'h0, 32'h0, 8'h00));
            // random mix over a few words so collisions happen
            for (int n = 0; n < 600; n++) begin
                op = $urandom_range(2, 0);
                if (op == 1) begin
                    fabOpc = RD;
                end else begin
                    fabOpc = WR;
                end
                r  = (op == 0) ? noFab : fabOp(fabOpc, 2'($urandom_range(3, 0)),
                                               8'($urandom_range(7, 0)), $urandom);
                op = $urandom_range(2, 0);
                c  = coreOp(op == 1, op == 2, 8'($urandom_range(7, 0)),
                            4'($urandom_range(15, 1)), $urandom, 8'($urandom));
                stepCycle(r, c);
            end
            coreChk = 1'b0;
            guard   = 0;
            while ((rspQ.size() + fetchQ.size() + coreQ.size()) != 0 && guard < 10) begin
                stepCycle(noFab, coreIdle(8'h00));
                guard++;
            end
            if ((rspQ.size() + fetchQ.size() + coreQ.size()) != 0) begin
                flowErrors++;
                $display("%0d expected results still outstanding after drain",
                         rspQ.size() + fetchQ.size() + coreQ.size());
            end
        end
        $display("checks %0d, errors %0d, flow errors %0d", nChecks, nErrors, flowErrors);
        if (nErrors == 0 && flowErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/gpcTilePkg.sv
verilog/instrMem.sv
verilog/dataMem.sv
verilog/fabricPort.sv
verilog/gpcTile.sv
tb/gpcTileTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the tile testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module gpcTileTb -f flist.f -o gpcTileSim

simOut=$(./obj_dir/gpcTileSim)
echo "$simOut"

if echo "$simOut" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
